//--- lsu_top.f
common/lsu_pkg.sv
lsu/lsu_agen.sv
lsu/lsu_dcache.sv
lsu/lsu_ex.sv
source/lsu_top.sv
bench/lsu_top_assert.sv
bench/lsu_top_tb.sv

//--- Makefile
# Verilator build and run for the LSU back end

VERILATOR ?= verilator
TOP       ?= lsu_top_tb
FLIST     ?= lsu_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf $(OBJ_DIR)

//--- bench/lsu_top_tb.sv
// LSU back end testbench: directed and random requests against a reference cache model
`default_nettype none

module lsu_top_tb;

    import lsu_pkg::*;

    typedef struct packed {
        logic                     valid;
        logic                     chk_data;
        logic [DATA_WIDTH-1:0]    data;
        logic [ADDR_WIDTH-1:0]    addr;
        logic [ROB_IDX_WIDTH-1:0] tag;
        logic                     lq_en;
        logic [LQ_DEPTH-1:0]      lq_sel;
        logic                     lq_retry;
        logic                     sq_en;
        logic [SQ_DEPTH-1:0]      sq_sel;
        logic                     sq_retry;
        logic                     vic_en;
        logic [ADDR_WIDTH-1:0]    vic_addr;
        logic [DC_LINE_WIDTH-1:0] vic_data;
    } exp_t;

    localparam int DRAIN_LIMIT = 50;

    logic clk = 1'b0;
    logic n_rst, i_flush, i_valid, i_retire;
    logic [LSU_FUNC_WIDTH-1:0] i_lsu_func;
    logic [LQ_DEPTH-1:0] i_lq_select;
    logic [SQ_DEPTH-1:0] i_sq_select;
    logic [ROB_IDX_WIDTH-1:0] i_tag;
    logic [ADDR_WIDTH-1:0] i_base, i_offset, o_addr, o_victim_addr;
    logic [DATA_WIDTH-1:0] i_store_data, o_data;
    logic [DC_LINE_WIDTH-1:0] i_fill_data, o_victim_data;
    logic o_valid, o_update_lq_en, o_update_lq_retry, o_update_sq_en, o_update_sq_retry;
    logic o_victim_en;
    logic [ROB_IDX_WIDTH-1:0] o_tag;
    logic [LQ_DEPTH-1:0] o_update_lq_select;
    logic [SQ_DEPTH-1:0] o_update_sq_select;

    exp_t cur, pipe1, pipe2, pipe3;                     // Expected outputs, 3 deep

    logic [DC_LINE_WIDTH-1:0] m_data [DC_NUM_LINES];   // Reference cache
    logic [DC_TAG_WIDTH-1:0]  m_tag  [DC_NUM_LINES];
    logic [DC_NUM_LINES-1:0]  m_valid, m_dirty;

    int errs = 0;
    int err_mark, tests_run, tests_failed;
    int seed;

    lsu_top u_lsu_top (.*);

    always #20 clk = ~clk;

    function automatic exp_t killed(exp_t e);
        e.valid = 1'b0;
        e.lq_en = 1'b0;
        e.sq_en = 1'b0;
        e.vic_en = 1'b0;
        return e;
    endfunction

    // Flush drops the request entering agen and the one leaving the cache stage
    always @(posedge clk) begin
        if (!n_rst) begin
            pipe1 <= '0;
            pipe2 <= '0;
            pipe3 <= '0;
        end else begin
            pipe1 <= i_flush ? killed(cur) : cur;
            pipe2 <= pipe1;
            pipe3 <= i_flush ? killed(pipe2) : pipe2;
        end
    end

    task automatic check(input string name, input logic [DC_LINE_WIDTH-1:0] got,
                         input logic [DC_LINE_WIDTH-1:0] exp);
        assert (got === exp) else begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            errs++;
        end
    endtask

    always @(negedge clk) begin
        if (n_rst) begin
            check("o_valid", o_valid, pipe3.valid);
            check("o_update_lq_en", o_update_lq_en, pipe3.lq_en);
            check("o_update_sq_en", o_update_sq_en, pipe3.sq_en);
            check("o_victim_en", o_victim_en, pipe3.vic_en);
            if (pipe3.valid) begin
                check("o_addr", o_addr, pipe3.addr);
                check("o_tag", o_tag, pipe3.tag);
                if (pipe3.chk_data) check("o_data", o_data, pipe3.data);
            end
            if (pipe3.lq_en) begin
                check("o_update_lq_select", o_update_lq_select, pipe3.lq_sel);
                check("o_update_lq_retry", o_update_lq_retry, pipe3.lq_retry);
            end
            if (pipe3.sq_en) begin
                check("o_update_sq_select", o_update_sq_select, pipe3.sq_sel);
                check("o_update_sq_retry", o_update_sq_retry, pipe3.sq_retry);
            end
            if (pipe3.vic_en) begin
                check("o_victim_addr", o_victim_addr, pipe3.vic_addr);
                check("o_victim_data", o_victim_data, pipe3.vic_data);
            end
        end
    end

    function automatic logic [3:0] aligned_off(input logic [2:0] func);
        logic [3:0] off;
        off = 4'($urandom % 16);
        if (func == LSU_FUNC_LH || func == LSU_FUNC_SH) off[0] = 1'b0;
        if (func == LSU_FUNC_LW || func == LSU_FUNC_SW) off[1:0] = 2'b00;
        return off;
    endfunction

    function automatic logic [2:0] rand_load();
        logic [2:0] f;
        f = 3'($urandom % 3);                              // LB, LH or LW
        return f;
    endfunction

    task automatic issue(input logic [2:0] func, input logic [ADDR_WIDTH-1:0] addr,
                         input logic retire, input logic flush);
        logic [2:0] idx;
        logic [3:0] off;
        logic hit;
        logic [DATA_WIDTH-1:0] sdata;
        logic [DC_LINE_WIDTH-1:0] fdata;
        logic [DC_LINE_WIDTH-1:0] line;
        exp_t e;
        idx = addr[6:4];
        off = addr[3:0];
        hit = m_valid[idx] && m_tag[idx] == addr[31:7];
        line = m_data[idx];
        sdata = $urandom;
        fdata = {$urandom, $urandom, $urandom, $urandom};
        e = '0;
        e.addr = addr;
        e.tag = 5'($urandom);
        e.lq_sel = 8'b1 << ($urandom % 8);
        e.sq_sel = 8'b1 << ($urandom % 8);
        e.lq_retry = !hit;
        e.sq_retry = !hit;
        case (func)
            LSU_FUNC_LB, LSU_FUNC_LH, LSU_FUNC_LW: begin
                e.valid = hit;
                e.chk_data = 1'b1;
                e.lq_en = 1'b1;
                e.data = line[off*8 +: 32];
                if (func == LSU_FUNC_LB) e.data = {{24{line[off*8+7]}}, line[off*8 +: 8]};
                if (func == LSU_FUNC_LH) e.data = {{16{line[off*8+15]}}, line[off*8 +: 16]};
            end
            LSU_FUNC_FILL: begin
                e.addr[3:0] = 4'h0;
                e.vic_en = m_valid[idx] && m_dirty[idx];
                e.vic_addr = {m_tag[idx], idx, 4'h0};
                e.vic_data = line;
                m_data[idx] = fdata;
                m_tag[idx] = addr[31:7];
                m_valid[idx] = 1'b1;
                m_dirty[idx] = 1'b0;
            end
            default: begin
                e.valid = !retire;                         // First pass goes to the CDB
                e.sq_en = retire;
                if (retire && hit) begin
                    if (func == LSU_FUNC_SB) line[off*8 +: 8] = sdata[7:0];
                    else if (func == LSU_FUNC_SH) line[off*8 +: 16] = sdata[15:0];
                    else line[off*8 +: 32] = sdata;
                    m_data[idx] = line;
                    m_dirty[idx] = 1'b1;
                end
            end
        endcase
        i_valid = 1'b1;
        i_flush = flush;
        i_lsu_func = func;
        i_base = $urandom;
        i_offset = addr - i_base;
        i_retire = retire;
        i_tag = e.tag;
        i_lq_select = e.lq_sel;
        i_sq_select = e.sq_sel;
        i_store_data = sdata;
        i_fill_data = fdata;
        cur = e;
        @(posedge clk);
        #2;
        i_valid = 1'b0;
        i_flush = 1'b0;
        cur = '0;
    endtask

    task automatic drain();
        int n;
        for (n = 0; n < DRAIN_LIMIT && (pipe1 != '0 || pipe2 != '0 || pipe3 != '0); n++) begin
            @(posedge clk);
            #2;
        end
        if (pipe1 != '0 || pipe2 != '0 || pipe3 != '0) begin
            $display("Timeout: pipeline did not drain");
            $display(">>> FAIL");
            $finish;
        end
    endtask

    function automatic int total_errs();
        return errs + u_lsu_top.u_lsu_top_assert.err_count;
    endfunction

    task automatic end_test(input string name);
        drain();
        repeat (2) @(posedge clk);
        #2;
        tests_run++;
        if (total_errs() == err_mark) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, total_errs() - err_mark);
            tests_failed++;
        end
        err_mark = total_errs();
    endtask

    initial begin
        logic [2:0] f;
        logic [2:0] idx;
        seed = 32'h030d90cb;
        void'($urandom(seed));
        {n_rst, i_flush, i_valid, i_retire, i_lsu_func} = '0;
        {i_lq_select, i_sq_select, i_tag, i_base, i_offset, i_store_data} = '0;
        i_fill_data = '0;
        cur = '0;
        m_valid = '0;
        m_dirty = '0;
        err_mark = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (16) @(posedge clk);
        #2;
        n_rst = 1'b1;
        repeat (4) @(posedge clk);
        #2;
        end_test("reset");

        for (int i = 0; i < 6; i++) begin                  // Lines 6 and 7 stay empty
            issue(LSU_FUNC_FILL, {25'($urandom), 3'(i), 4'($urandom)}, 1'b0, 1'b0);
        end
        for (int i = 0; i < 24; i++) begin
            f = rand_load();
            idx = 3'($urandom % 6);
            issue(f, {m_tag[idx], idx, aligned_off(f)}, 1'b0, 1'b0);
        end
        end_test("fill_load");

        for (int i = 0; i < 8; i++) begin
            f = rand_load();
            idx = 3'(6 + i % 2);
            issue(f, {25'($urandom), idx, aligned_off(f)}, 1'b0, 1'b0);
            idx = 3'($urandom % 6);
            issue(f, {m_tag[idx] ^ 25'h1, idx, aligned_off(f)}, 1'b0, 1'b0);
        end
        end_test("load_miss");

        for (int i = 0; i < 6; i++) begin
            f = 3'(LSU_FUNC_SB + i % 3);
            idx = 3'($urandom % 6);
            issue(f, {m_tag[idx], idx, aligned_off(f)}, 1'b0, 1'b0);
        end
        for (int i = 0; i < 9; i++) begin
            f = 3'(LSU_FUNC_SB + i % 3);
            issue(f, {m_tag[1], 3'd1, aligned_off(f)}, 1'b1, 1'b0);
            issue(LSU_FUNC_LW, {m_tag[1], 3'd1, 2'($urandom), 2'b00}, 1'b0, 1'b0);
        end
        issue(LSU_FUNC_SW, {m_tag[2] ^ 25'h4, 3'd2, 4'h8}, 1'b1, 1'b0);
        issue(LSU_FUNC_LW, {m_tag[2], 3'd2, 4'h8}, 1'b0, 1'b0);
        end_test("stores");

        issue(LSU_FUNC_FILL, {25'($urandom), 3'd1, 4'h0}, 1'b0, 1'b0);  // Dirty victim
        issue(LSU_FUNC_FILL, {25'($urandom), 3'd0, 4'h0}, 1'b0, 1'b0);  // Clean line
        issue(LSU_FUNC_LW, {m_tag[1], 3'd1, 4'h4}, 1'b0, 1'b0);
        end_test("victims");

        for (int i = 0; i < 6; i++) begin
            f = rand_load();
            idx = 3'($urandom % 6);
            issue(f, {m_tag[idx], idx, aligned_off(f)}, 1'b0, i >= 2);
        end
        issue(LSU_FUNC_SW, {m_tag[3], 3'd3, 4'h4}, 1'b1, 1'b0);
        issue(LSU_FUNC_FILL, {25'($urandom), 3'd3, 4'h0}, 1'b0, 1'b0);  // Dirty victim
        issue(LSU_FUNC_SW, {m_tag[4], 3'd4, 4'h0}, 1'b1, 1'b0);
        issue(LSU_FUNC_LW, {m_tag[5], 3'd5, 4'h0}, 1'b0, 1'b1);         // Fill sits in ex
        issue(LSU_FUNC_LW, {m_tag[5], 3'd5, 4'h4}, 1'b0, 1'b1);         // Store sits in ex
        end_test("flush");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 total_errs());
        if (total_errs() == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/lsu_top_assert.sv
// LSU protocol checks: reset state, one-hot queue selects, select echo and fixed latency
`default_nettype none

module lsu_top_assert (
    input logic                               clk,
    input logic                               n_rst,
    input logic                               i_flush,
    input logic                               i_valid,
    input logic [lsu_pkg::LSU_FUNC_WIDTH-1:0] i_lsu_func,
    input logic [lsu_pkg::LQ_DEPTH-1:0]       i_lq_select,
    input logic [lsu_pkg::SQ_DEPTH-1:0]       i_sq_select,
    input logic                               i_retire,
    input logic                               o_valid,
    input logic                               o_update_lq_en,
    input logic [lsu_pkg::LQ_DEPTH-1:0]       o_update_lq_select,
    input logic                               o_update_sq_en,
    input logic [lsu_pkg::SQ_DEPTH-1:0]       o_update_sq_select,
    input logic                               o_victim_en
);

    import lsu_pkg::*;

    int   err_count = 0;
    logic is_load;
    logic is_store;

    assign is_load  = (i_lsu_func == LSU_FUNC_LB) | (i_lsu_func == LSU_FUNC_LH) |
                      (i_lsu_func == LSU_FUNC_LW);
    assign is_store = (i_lsu_func == LSU_FUNC_SB) | (i_lsu_func == LSU_FUNC_SH) |
                      (i_lsu_func == LSU_FUNC_SW);

    // Every enable is low in the cycle after a reset edge
    reset_quiet: assert property (@(posedge clk) !n_rst |=>
        !o_valid && !o_update_lq_en && !o_update_sq_en && !o_victim_en)
        else begin $error("enable high after reset"); err_count++; end

    lq_onehot: assert property (@(posedge clk) disable iff (!n_rst)
        o_update_lq_en |-> ($onehot(o_update_lq_select) &&
                            o_update_lq_select == $past(i_lq_select, 3)))
        else begin $error("LQ select not one-hot or not the issued one"); err_count++; end

    sq_onehot: assert property (@(posedge clk) disable iff (!n_rst)
        o_update_sq_en |-> ($onehot(o_update_sq_select) &&
                            o_update_sq_select == $past(i_sq_select, 3)))
        else begin $error("SQ select not one-hot or not the issued one"); err_count++; end

    // Unflushed loads and retiring stores update their queue exactly 3 cycles on
    load_latency: assert property (@(posedge clk) disable iff (!n_rst)
        (i_valid && is_load && !i_flush) ##2 !i_flush |=> o_update_lq_en)
        else begin $error("load missed its LQ update"); err_count++; end

    store_latency: assert property (@(posedge clk) disable iff (!n_rst)
        (i_valid && is_store && i_retire && !i_flush) ##2 !i_flush |=> o_update_sq_en)
        else begin $error("retiring store missed its SQ update"); err_count++; end

    // A victim only follows a fill that no flush caught in agen or ex
    victim_source: assert property (@(posedge clk) disable iff (!n_rst)
        o_victim_en |-> ($past(i_valid && i_lsu_func == LSU_FUNC_FILL && !i_flush, 3) &&
                         !$past(i_flush)))
        else begin $error("victim without an unflushed fill"); err_count++; end

endmodule

bind lsu_top lsu_top_assert u_lsu_top_assert (
    .clk(clk), .n_rst(n_rst), .i_flush(i_flush), .i_valid(i_valid),
    .i_lsu_func(i_lsu_func), .i_lq_select(i_lq_select), .i_sq_select(i_sq_select),
    .i_retire(i_retire), .o_valid(o_valid), .o_update_lq_en(o_update_lq_en),
    .o_update_lq_select(o_update_lq_select), .o_update_sq_en(o_update_sq_en),
    .o_update_sq_select(o_update_sq_select), .o_victim_en(o_victim_en)
);

`default_nettype wire

//--- source/lsu_top.sv
// LSU back end top: address generation, data cache and execute stages in a 3-cycle pipeline
`default_nettype none

module lsu_top (
    input  logic                              clk,
    input  logic                              n_rst,

    input  logic                              i_flush,
    input  logic                              i_valid,
    input  logic [lsu_pkg::LSU_FUNC_WIDTH-1:0] i_lsu_func,
    input  logic [lsu_pkg::LQ_DEPTH-1:0]      i_lq_select,
    input  logic [lsu_pkg::SQ_DEPTH-1:0]      i_sq_select,
    input  logic [lsu_pkg::ROB_IDX_WIDTH-1:0] i_tag,
    input  logic [lsu_pkg::ADDR_WIDTH-1:0]    i_base,
    input  logic [lsu_pkg::ADDR_WIDTH-1:0]    i_offset,
    input  logic [lsu_pkg::DATA_WIDTH-1:0]    i_store_data,
    input  logic [lsu_pkg::DC_LINE_WIDTH-1:0] i_fill_data,
    input  logic                              i_retire,

    output logic                              o_valid,
    output logic [lsu_pkg::DATA_WIDTH-1:0]    o_data,
    output logic [lsu_pkg::ADDR_WIDTH-1:0]    o_addr,
    output logic [lsu_pkg::ROB_IDX_WIDTH-1:0] o_tag,
    output logic                              o_update_lq_en,
    output logic [lsu_pkg::LQ_DEPTH-1:0]      o_update_lq_select,
    output logic                              o_update_lq_retry,
    output logic                              o_update_sq_en,
    output logic [lsu_pkg::SQ_DEPTH-1:0]      o_update_sq_select,
    output logic                              o_update_sq_retry,
    output logic                              o_victim_en,
    output logic [lsu_pkg::ADDR_WIDTH-1:0]    o_victim_addr,
    output logic [lsu_pkg::DC_LINE_WIDTH-1:0] o_victim_data
);

    import lsu_pkg::*;

    logic                      agen_valid;
    logic [LSU_FUNC_WIDTH-1:0] agen_func;
    logic [ADDR_WIDTH-1:0]     agen_addr;
    logic [ROB_IDX_WIDTH-1:0]  agen_tag;
    logic [LQ_DEPTH-1:0]       agen_lq_select;
    logic [SQ_DEPTH-1:0]       agen_sq_select;
    logic                      agen_retire;
    logic [DATA_WIDTH-1:0]     agen_store_data;
    logic [DC_LINE_WIDTH-1:0]  agen_fill_data;

    logic                      dc_valid;
    logic [LSU_FUNC_WIDTH-1:0] dc_func;
    logic [ADDR_WIDTH-1:0]     dc_addr;
    logic [ROB_IDX_WIDTH-1:0]  dc_tag;
    logic [LQ_DEPTH-1:0]       dc_lq_select;
    logic [SQ_DEPTH-1:0]       dc_sq_select;
    logic                      dc_retire;
    logic                      dc_hit;
    logic [DATA_WIDTH-1:0]     dc_data;
    logic                      dc_victim_valid;
    logic                      dc_victim_dirty;
    logic [ADDR_WIDTH-1:0]     dc_victim_addr;
    logic [DC_LINE_WIDTH-1:0]  dc_victim_data;

    lsu_agen u_lsu_agen (
        .clk(clk), .n_rst(n_rst), .i_flush(i_flush),
        .i_valid(i_valid), .i_lsu_func(i_lsu_func), .i_lq_select(i_lq_select),
        .i_sq_select(i_sq_select), .i_tag(i_tag), .i_base(i_base), .i_offset(i_offset),
        .i_retire(i_retire), .i_store_data(i_store_data), .i_fill_data(i_fill_data),
        .o_valid(agen_valid), .o_lsu_func(agen_func), .o_lq_select(agen_lq_select),
        .o_sq_select(agen_sq_select), .o_tag(agen_tag), .o_addr(agen_addr),
        .o_retire(agen_retire), .o_store_data(agen_store_data), .o_fill_data(agen_fill_data)
    );

    lsu_dcache u_lsu_dcache (
        .clk(clk), .n_rst(n_rst),
        .i_valid(agen_valid), .i_lsu_func(agen_func), .i_addr(agen_addr), .i_tag(agen_tag),
        .i_lq_select(agen_lq_select), .i_sq_select(agen_sq_select), .i_retire(agen_retire),
        .i_store_data(agen_store_data), .i_fill_data(agen_fill_data),
        .o_valid(dc_valid), .o_lsu_func(dc_func), .o_addr(dc_addr), .o_tag(dc_tag),
        .o_lq_select(dc_lq_select), .o_sq_select(dc_sq_select), .o_retire(dc_retire),
        .o_hit(dc_hit), .o_data(dc_data), .o_victim_valid(dc_victim_valid),
        .o_victim_dirty(dc_victim_dirty), .o_victim_addr(dc_victim_addr),
        .o_victim_data(dc_victim_data)
    );

    lsu_ex u_lsu_ex (
        .clk(clk), .n_rst(n_rst), .i_flush(i_flush),
        .i_valid(dc_valid), .i_lsu_func(dc_func), .i_lq_select(dc_lq_select),
        .i_sq_select(dc_sq_select), .i_tag(dc_tag), .i_addr(dc_addr), .i_retire(dc_retire),
        .i_dc_hit(dc_hit), .i_dc_data(dc_data), .i_dc_victim_valid(dc_victim_valid),
        .i_dc_victim_dirty(dc_victim_dirty), .i_dc_victim_addr(dc_victim_addr),
        .i_dc_victim_data(dc_victim_data),
        .o_valid(o_valid), .o_data(o_data), .o_addr(o_addr), .o_tag(o_tag),
        .o_update_lq_en(o_update_lq_en), .o_update_lq_select(o_update_lq_select),
        .o_update_lq_retry(o_update_lq_retry), .o_update_sq_en(o_update_sq_en),
        .o_update_sq_select(o_update_sq_select), .o_update_sq_retry(o_update_sq_retry),
        .o_victim_en(o_victim_en), .o_victim_addr(o_victim_addr),
        .o_victim_data(o_victim_data)
    );

endmodule

`default_nettype wire

//--- lsu/lsu_ex.sv
// LSU execute stage: load sign extension, CDB broadcast, queue updates and victim enqueue
`default_nettype none

module lsu_ex (
    input  logic                              clk,
    input  logic                              n_rst,

    input  logic                              i_flush,

    input  logic                              i_valid,
    input  logic [lsu_pkg::LSU_FUNC_WIDTH-1:0] i_lsu_func,
    input  logic [lsu_pkg::LQ_DEPTH-1:0]      i_lq_select,
    input  logic [lsu_pkg::SQ_DEPTH-1:0]      i_sq_select,
    input  logic [lsu_pkg::ROB_IDX_WIDTH-1:0] i_tag,
    input  logic [lsu_pkg::ADDR_WIDTH-1:0]    i_addr,
    input  logic                              i_retire,

    input  logic                              i_dc_hit,
    input  logic [lsu_pkg::DATA_WIDTH-1:0]    i_dc_data,
    input  logic                              i_dc_victim_valid,
    input  logic                              i_dc_victim_dirty,
    input  logic [lsu_pkg::ADDR_WIDTH-1:0]    i_dc_victim_addr,
    input  logic [lsu_pkg::DC_LINE_WIDTH-1:0] i_dc_victim_data,

    output logic                              o_valid,
    output logic [lsu_pkg::DATA_WIDTH-1:0]    o_data,
    output logic [lsu_pkg::ADDR_WIDTH-1:0]    o_addr,
    output logic [lsu_pkg::ROB_IDX_WIDTH-1:0] o_tag,

    output logic                              o_update_lq_en,
    output logic [lsu_pkg::LQ_DEPTH-1:0]      o_update_lq_select,
    output logic                              o_update_lq_retry,
    output logic                              o_update_sq_en,
    output logic [lsu_pkg::SQ_DEPTH-1:0]      o_update_sq_select,
    output logic                              o_update_sq_retry,

    output logic                              o_victim_en,
    output logic [lsu_pkg::ADDR_WIDTH-1:0]    o_victim_addr,
    output logic [lsu_pkg::DC_LINE_WIDTH-1:0] o_victim_data
);

    import lsu_pkg::*;

    logic                  is_load;
    logic                  is_store;
    logic                  is_fill;
    logic [DATA_WIDTH-1:0] load_data;

    assign is_load  = (i_lsu_func == LSU_FUNC_LB) | (i_lsu_func == LSU_FUNC_LH) |
                      (i_lsu_func == LSU_FUNC_LW);
    assign is_store = (i_lsu_func == LSU_FUNC_SB) | (i_lsu_func == LSU_FUNC_SH) |
                      (i_lsu_func == LSU_FUNC_SW);
    assign is_fill  = i_lsu_func == LSU_FUNC_FILL;

    always_comb begin
        case (i_lsu_func)
            LSU_FUNC_LB: load_data = {{(DATA_WIDTH-8){i_dc_data[7]}}, i_dc_data[7:0]};
            LSU_FUNC_LH: load_data = {{(DATA_WIDTH/2){i_dc_data[DATA_WIDTH/2-1]}},
                                      i_dc_data[DATA_WIDTH/2-1:0]};
            default:     load_data = i_dc_data;
        endcase
    end

    always_ff @(posedge clk) begin
        o_data             <= load_data;
        o_addr             <= i_addr;
        o_tag              <= i_tag;
        o_update_lq_select <= i_lq_select;
        o_update_lq_retry  <= ~i_dc_hit;   // Miss sends the load back to the LQ
        o_update_sq_select <= i_sq_select;
        o_update_sq_retry  <= ~i_dc_hit;
        o_victim_addr      <= i_dc_victim_addr;
        o_victim_data      <= i_dc_victim_data;
    end

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            o_valid        <= 1'b0;
            o_update_lq_en <= 1'b0;
            o_update_sq_en <= 1'b0;
            o_victim_en    <= 1'b0;
        end else begin
            // Load hits and first-pass stores go to the CDB
            o_valid        <= i_valid & ~i_flush &
                              ((is_load & i_dc_hit) | (is_store & ~i_retire));
            o_update_lq_en <= i_valid & ~i_flush & is_load;
            o_update_sq_en <= i_valid & ~i_flush & is_store & i_retire;
            o_victim_en    <= i_valid & ~i_flush & is_fill &
                              i_dc_victim_valid & i_dc_victim_dirty; // Dirty old line leaves
        end
    end

endmodule

`default_nettype wire

//--- lsu/lsu_dcache.sv
// LSU data cache stage: direct-mapped write-back cache with lookup, store merge and line fill
`default_nettype none

module lsu_dcache (
    input  logic                              clk,
    input  logic                              n_rst,

    input  logic                              i_valid,
    input  logic [lsu_pkg::LSU_FUNC_WIDTH-1:0] i_lsu_func,
    input  logic [lsu_pkg::ADDR_WIDTH-1:0]    i_addr,
    input  logic [lsu_pkg::ROB_IDX_WIDTH-1:0] i_tag,
    input  logic [lsu_pkg::LQ_DEPTH-1:0]      i_lq_select,
    input  logic [lsu_pkg::SQ_DEPTH-1:0]      i_sq_select,
    input  logic                              i_retire,
    input  logic [lsu_pkg::DATA_WIDTH-1:0]    i_store_data,
    input  logic [lsu_pkg::DC_LINE_WIDTH-1:0] i_fill_data,

    output logic                              o_valid,
    output logic [lsu_pkg::LSU_FUNC_WIDTH-1:0] o_lsu_func,
    output logic [lsu_pkg::ADDR_WIDTH-1:0]    o_addr,
    output logic [lsu_pkg::ROB_IDX_WIDTH-1:0] o_tag,
    output logic [lsu_pkg::LQ_DEPTH-1:0]      o_lq_select,
    output logic [lsu_pkg::SQ_DEPTH-1:0]      o_sq_select,
    output logic                              o_retire,

    output logic                              o_hit,
    output logic [lsu_pkg::DATA_WIDTH-1:0]    o_data,
    output logic                              o_victim_valid,
    output logic                              o_victim_dirty,
    output logic [lsu_pkg::ADDR_WIDTH-1:0]    o_victim_addr,
    output logic [lsu_pkg::DC_LINE_WIDTH-1:0] o_victim_data
);

    import lsu_pkg::*;

    logic [DC_LINE_WIDTH-1:0]   data_array [DC_NUM_LINES];
    logic [DC_TAG_WIDTH-1:0]    tag_array  [DC_NUM_LINES];
    logic [DC_NUM_LINES-1:0]    valid_bits;
    logic [DC_NUM_LINES-1:0]    dirty_bits;

    logic [DC_TAG_WIDTH-1:0]    req_tag;
    logic [DC_INDEX_WIDTH-1:0]  req_index;
    logic [DC_OFFSET_WIDTH-1:0] req_offset;
    logic [DC_OFFSET_WIDTH+2:0] bit_shift;

    logic                       is_store;
    logic                       is_fill;
    logic                       hit;
    logic                       store_wr;
    logic                       fill_wr;

    logic [DC_LINE_WIDTH-1:0]   cur_line;
    logic [DC_LINE_WIDTH-1:0]   shifted_line;
    logic [DATA_WIDTH-1:0]      word_mask;
    logic [DC_LINE_WIDTH-1:0]   line_mask;
    logic [DC_LINE_WIDTH-1:0]   line_wdata;
    logic [DC_LINE_WIDTH-1:0]   merged_line;

    assign {req_tag, req_index, req_offset} = i_addr;
    assign bit_shift = {req_offset, 3'b000};

    assign is_store = (i_lsu_func == LSU_FUNC_SB) | (i_lsu_func == LSU_FUNC_SH) |
                      (i_lsu_func == LSU_FUNC_SW);
    assign is_fill  = i_lsu_func == LSU_FUNC_FILL;

    // Reads are combinational off the array, so a write at one edge is seen by the next request
    assign cur_line = data_array[req_index];
    assign hit      = valid_bits[req_index] & (tag_array[req_index] == req_tag);

    assign shifted_line = cur_line >> bit_shift; // Addressed byte lands at bit 0

    always_comb begin
        case (i_lsu_func)
            LSU_FUNC_SB: word_mask = {{(DATA_WIDTH-8){1'b0}}, 8'hff};
            LSU_FUNC_SH: word_mask = {{(DATA_WIDTH/2){1'b0}}, {(DATA_WIDTH/2){1'b1}}};
            default:     word_mask = '1;
        endcase
    end

    assign line_mask   = {{(DC_LINE_WIDTH-DATA_WIDTH){1'b0}}, word_mask} << bit_shift;
    assign line_wdata  = {{(DC_LINE_WIDTH-DATA_WIDTH){1'b0}}, i_store_data} << bit_shift;
    assign merged_line = (cur_line & ~line_mask) | (line_wdata & line_mask);

    assign store_wr = i_valid & is_store & i_retire & hit; // Only committed stores touch the array
    assign fill_wr  = i_valid & is_fill;

    always_ff @(posedge clk) begin
        if (fill_wr) begin
            data_array[req_index] <= i_fill_data;
            tag_array[req_index]  <= req_tag;
        end else if (store_wr) begin
            data_array[req_index] <= merged_line;
        end
    end

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (fill_wr) begin
            valid_bits[req_index] <= 1'b1;
            dirty_bits[req_index] <= 1'b0; // Fresh line matches memory
        end else if (store_wr) begin
            dirty_bits[req_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        o_lsu_func  <= i_lsu_func;
        o_addr      <= i_addr;
        o_tag       <= i_tag;
        o_lq_select <= i_lq_select;
        o_sq_select <= i_sq_select;
        o_retire    <= i_retire;
        o_hit       <= hit;
        o_data      <= shifted_line[DATA_WIDTH-1:0];
    end

    // Old line at the index, sampled before any fill overwrites it
    always_ff @(posedge clk) begin
        o_victim_valid <= valid_bits[req_index];
        o_victim_dirty <= dirty_bits[req_index];
        o_victim_addr  <= {tag_array[req_index], req_index, {DC_OFFSET_WIDTH{1'b0}}};
        o_victim_data  <= cur_line;
    end

endmodule

`default_nettype wire

//--- lsu/lsu_agen.sv
// LSU address generation stage: computes the effective address and registers the request
`default_nettype none

module lsu_agen (
    input  logic                              clk,
    input  logic                              n_rst,

    input  logic                              i_flush,

    input  logic                              i_valid,
    input  logic [lsu_pkg::LSU_FUNC_WIDTH-1:0] i_lsu_func,
    input  logic [lsu_pkg::LQ_DEPTH-1:0]      i_lq_select,
    input  logic [lsu_pkg::SQ_DEPTH-1:0]      i_sq_select,
    input  logic [lsu_pkg::ROB_IDX_WIDTH-1:0] i_tag,
    input  logic [lsu_pkg::ADDR_WIDTH-1:0]    i_base,
    input  logic [lsu_pkg::ADDR_WIDTH-1:0]    i_offset,
    input  logic                              i_retire,
    input  logic [lsu_pkg::DATA_WIDTH-1:0]    i_store_data,
    input  logic [lsu_pkg::DC_LINE_WIDTH-1:0] i_fill_data,

    output logic                              o_valid,
    output logic [lsu_pkg::LSU_FUNC_WIDTH-1:0] o_lsu_func,
    output logic [lsu_pkg::LQ_DEPTH-1:0]      o_lq_select,
    output logic [lsu_pkg::SQ_DEPTH-1:0]      o_sq_select,
    output logic [lsu_pkg::ROB_IDX_WIDTH-1:0] o_tag,
    output logic [lsu_pkg::ADDR_WIDTH-1:0]    o_addr,
    output logic                              o_retire,
    output logic [lsu_pkg::DATA_WIDTH-1:0]    o_store_data,
    output logic [lsu_pkg::DC_LINE_WIDTH-1:0] o_fill_data
);

    import lsu_pkg::*;

    logic [ADDR_WIDTH-1:0] eff_addr;
    logic [ADDR_WIDTH-1:0] req_addr;

    assign eff_addr = i_base + i_offset;

    always_comb begin
        req_addr = eff_addr;
        if (i_lsu_func == LSU_FUNC_FILL) begin
            req_addr[DC_OFFSET_WIDTH-1:0] = '0; // Fills always target a whole line
        end
    end

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid & ~i_flush;     // Flush drops the incoming request
        end
    end

    always_ff @(posedge clk) begin
        o_lsu_func   <= i_lsu_func;
        o_lq_select  <= i_lq_select;
        o_sq_select  <= i_sq_select;
        o_tag        <= i_tag;
        o_addr       <= req_addr;
        o_retire     <= i_retire;
        o_store_data <= i_store_data;
        o_fill_data  <= i_fill_data;
    end

endmodule

`default_nettype wire

//--- common/lsu_pkg.sv
// LSU shared definitions: datapath widths, queue depths, function codes and cache geometry
`default_nettype none

package lsu_pkg;

    // Datapath
    localparam int DATA_WIDTH      = 32;
    localparam int ADDR_WIDTH      = 32;

    // One-hot queue selects and ROB tag
    localparam int LQ_DEPTH        = 8;
    localparam int SQ_DEPTH        = 8;
    localparam int ROB_IDX_WIDTH   = 5;

    // Direct-mapped data cache geometry
    localparam int DC_LINE_SIZE    = 16;                // Bytes per line
    localparam int DC_LINE_WIDTH   = DC_LINE_SIZE * 8;
    localparam int DC_NUM_LINES    = 8;
    localparam int DC_OFFSET_WIDTH = $clog2(DC_LINE_SIZE);
    localparam int DC_INDEX_WIDTH  = $clog2(DC_NUM_LINES);
    localparam int DC_TAG_WIDTH    = ADDR_WIDTH - DC_INDEX_WIDTH - DC_OFFSET_WIDTH;

    // LSU function codes
    localparam int LSU_FUNC_WIDTH  = 3;

    // Loads sit in the low half, stores have bit 2 set
    localparam logic [LSU_FUNC_WIDTH-1:0] LSU_FUNC_LB   = 3'b000;
    localparam logic [LSU_FUNC_WIDTH-1:0] LSU_FUNC_LH   = 3'b001;
    localparam logic [LSU_FUNC_WIDTH-1:0] LSU_FUNC_LW   = 3'b010;
    localparam logic [LSU_FUNC_WIDTH-1:0] LSU_FUNC_SB   = 3'b100;
    localparam logic [LSU_FUNC_WIDTH-1:0] LSU_FUNC_SH   = 3'b101;
    localparam logic [LSU_FUNC_WIDTH-1:0] LSU_FUNC_SW   = 3'b110;
    localparam logic [LSU_FUNC_WIDTH-1:0] LSU_FUNC_FILL = 3'b111; // Line refill from memory

endpackage

`default_nettype wire
